/* design/axi_beat_pkg.sv */
`default_nettype none

// Slave port beat description
// Widths of the ID, address, data and strobe fields of one single-beat transfer

package axi_beat_pkg;

  // Transaction ID carried from request to response
  localparam int unsigned ID_W     = 4;
  // Byte address of a beat
  localparam int unsigned ADDR_W   = 16;

  // One beat is 64 bits with one strobe per byte
  localparam int unsigned DATA_W   = 64;
  localparam int unsigned STRB_W   = DATA_W / 8;
  // Low address bits that select a byte inside the beat
  localparam int unsigned OFFSET_W = $clog2(STRB_W);

endpackage

`default_nettype wire

/* design/mem_bank_pkg.sv */
`default_nettype none

// SRAM bank array description
// Bank count and width, row addressing and the in-flight limits of each path

package mem_bank_pkg;

  // Two 32-bit banks side by side hold one beat
  localparam int unsigned NUM_BANKS   = 2;
  localparam int unsigned BANK_DATA_W = 32;
  localparam int unsigned BANK_STRB_W = BANK_DATA_W / 8;

  // Row is the beat address without its byte offset
  localparam int unsigned ROW_W = axi_beat_pkg::ADDR_W - axi_beat_pkg::OFFSET_W;

  // Most beats in flight on one path
  localparam int unsigned RSP_DEPTH   = 4;
  localparam int unsigned RSP_PTR_W   = $clog2(RSP_DEPTH);
  localparam int unsigned RSP_CNT_W   = $clog2(RSP_DEPTH + 1);
  // One spare slot covers a grant in the same cycle as a full store
  localparam int unsigned ROUTE_DEPTH = RSP_DEPTH + 1;
  localparam int unsigned ROUTE_PTR_W = $clog2(ROUTE_DEPTH);

endpackage

`default_nettype wire

/* design/beat_decoder.sv */
`default_nettype none

// Beat decoder for one path of the memory port
// Accepts a beat, works out which banks it needs and requests each of them
// Holds the beat until every needed bank has granted

module beat_decoder
  import axi_beat_pkg::*;
  import mem_bank_pkg::*;
#(
  // Set for the write path, clear for the read path
  parameter bit WRITE_PATH = 1'b0
) (
  input  wire logic                                  clk_i,
  input  wire logic                                  arst_n_i,
  // Beat from the slave port
  input  wire logic                                  req_valid_i,
  output logic                                       req_ready_o,
  input  wire logic [ID_W-1:0]                       req_id_i,
  input  wire logic [ADDR_W-1:0]                     req_addr_i,
  input  wire logic [DATA_W-1:0]                     req_wdata_i,
  input  wire logic [STRB_W-1:0]                     req_strb_i,
  // One request line per bank arbiter
  output logic      [NUM_BANKS-1:0]                  path_req_o,
  input  wire logic [NUM_BANKS-1:0]                  path_gnt_i,
  output logic      [ROW_W-1:0]                      path_row_o,
  output logic      [NUM_BANKS-1:0][BANK_DATA_W-1:0] path_wdata_o,
  output logic      [NUM_BANKS-1:0][BANK_STRB_W-1:0] path_strb_o,
  output logic                                       path_we_o,
  // Entry for the beat collector of this path
  output logic                                       cq_push_o,
  output logic      [ID_W-1:0]                       cq_id_o,
  output logic      [NUM_BANKS-1:0]                  cq_mask_o,
  input  wire logic                                  cq_full_i,
  output logic                                       busy_o
);

  // Low during reset and released one cycle later
  logic                                  run_q;
  // Banks still waiting for a grant
  logic [NUM_BANKS-1:0]                  pending_q;
  logic [NUM_BANKS-1:0]                  need_mask;
  logic                                  take;
  // Registered beat payload
  logic [ROW_W-1:0]                      row_q;
  logic [NUM_BANKS-1:0][BANK_DATA_W-1:0] wdata_q;
  logic [NUM_BANKS-1:0][BANK_STRB_W-1:0] strb_q;

  // A write only needs banks with at least one strobe set
  if (WRITE_PATH) begin : g_write_mask
    for (genvar k = 0; k < NUM_BANKS; k++) begin : g_bank
      assign need_mask[k] = |req_strb_i[k*BANK_STRB_W +: BANK_STRB_W];
    end
  end else begin : g_read_mask
    // Reads always fetch the whole beat
    assign need_mask = '1;
  end

  // Free only with no beat held and room in the collector queue
  assign req_ready_o = run_q & ~(|pending_q) & ~cq_full_i;
  assign take        = req_valid_i & req_ready_o;

  // Collector learns the ID and the bank mask at acceptance
  assign cq_push_o = take;
  assign cq_id_o   = req_id_i;
  assign cq_mask_o = need_mask;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      run_q     <= 1'b0;
      pending_q <= '0;
    end else begin
      run_q <= 1'b1;
      if (take) begin
        pending_q <= need_mask;
      end else begin
        // Each bank drops out on its own grant
        pending_q <= pending_q & ~path_gnt_i;
      end
    end
  end

  // Payload captured on acceptance
  always_ff @(posedge clk_i) begin
    if (take) begin
      row_q   <= req_addr_i[ADDR_W-1:OFFSET_W];
      wdata_q <= req_wdata_i;
      strb_q  <= req_strb_i;
    end
  end

  assign path_req_o   = pending_q;
  // Same row on every bank
  assign path_row_o   = row_q;
  assign path_wdata_o = wdata_q;
  assign path_strb_o  = strb_q;
  assign path_we_o    = WRITE_PATH;

  assign busy_o = |pending_q;

endmodule

`default_nettype wire

/* design/bank_arbiter.sv */
`default_nettype none

// Bank arbiter for one SRAM bank
// Round-robin choice between the read and the write path
// Route store sends each bank response back to the path that was granted

module bank_arbiter
  import mem_bank_pkg::*;
(
  input  wire logic                   clk_i,
  input  wire logic                   arst_n_i,
  // Read path
  input  wire logic                   rd_req_i,
  output logic                        rd_gnt_o,
  input  wire logic [ROW_W-1:0]       rd_row_i,
  // Write path
  input  wire logic                   wr_req_i,
  output logic                        wr_gnt_o,
  input  wire logic [ROW_W-1:0]       wr_row_i,
  input  wire logic [BANK_DATA_W-1:0] wr_wdata_i,
  input  wire logic [BANK_STRB_W-1:0] wr_strb_i,
  // SRAM bank
  output logic                        mem_req_o,
  input  wire logic                   mem_gnt_i,
  output logic      [ROW_W-1:0]       mem_row_o,
  output logic      [BANK_DATA_W-1:0] mem_wdata_o,
  output logic      [BANK_STRB_W-1:0] mem_strb_o,
  output logic                        mem_we_o,
  input  wire logic                   mem_rvalid_i,
  // Response routed to one path
  output logic                        rd_rvalid_o,
  output logic                        wr_rvalid_o
);

  // Write wins a tie when set
  logic                   prio_q;
  logic                   sel_wr;
  logic                   granted;
  // Route store bit is high for a granted write and low for a granted read
  logic [ROUTE_DEPTH-1:0] route_q;
  logic [ROUTE_PTR_W-1:0] push_ptr_q;
  logic [ROUTE_PTR_W-1:0] pop_ptr_q;
  logic                   route_head;

  function automatic logic [ROUTE_PTR_W-1:0] route_ptr_next(logic [ROUTE_PTR_W-1:0] ptr);
    return (ptr == ROUTE_PTR_W'(ROUTE_DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  // Winner picked purely from the current requests
  assign sel_wr    = wr_req_i & (~rd_req_i | prio_q);
  assign mem_req_o = rd_req_i | wr_req_i;
  assign granted   = mem_req_o & mem_gnt_i;

  assign rd_gnt_o = rd_req_i & ~sel_wr & mem_gnt_i;
  assign wr_gnt_o = sel_wr & mem_gnt_i;

  // Forward the winner's payload
  assign mem_row_o   = sel_wr ? wr_row_i : rd_row_i;
  assign mem_wdata_o = sel_wr ? wr_wdata_i : '0;
  assign mem_strb_o  = sel_wr ? wr_strb_i : '0;
  assign mem_we_o    = sel_wr;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      prio_q     <= 1'b0;
      push_ptr_q <= '0;
      pop_ptr_q  <= '0;
    end else begin
      // Pointer only moves after a contested grant
      if (granted && rd_req_i && wr_req_i) begin
        prio_q <= ~prio_q;
      end
      if (granted) begin
        push_ptr_q <= route_ptr_next(push_ptr_q);
      end
      if (mem_rvalid_i) begin
        pop_ptr_q <= route_ptr_next(pop_ptr_q);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (granted) begin
      route_q[push_ptr_q] <= sel_wr;
    end
  end

  // Responses come back in grant order so the head names the path
  assign route_head  = route_q[pop_ptr_q];
  assign rd_rvalid_o = mem_rvalid_i & ~route_head;
  assign wr_rvalid_o = mem_rvalid_i & route_head;

endmodule

`default_nettype wire

/* design/beat_collector.sv */
`default_nettype none

// Beat collector for one path of the memory port
// Buffers bank responses and joins them into whole beats in request order
// Presents each finished beat as an R or B response

module beat_collector
  import axi_beat_pkg::*;
  import mem_bank_pkg::*;
(
  input  wire logic                                  clk_i,
  input  wire logic                                  arst_n_i,
  // Entries from the beat decoder
  input  wire logic                                  cq_push_i,
  input  wire logic [ID_W-1:0]                       cq_id_i,
  input  wire logic [NUM_BANKS-1:0]                  cq_mask_i,
  output logic                                       cq_full_o,
  // Routed bank responses
  input  wire logic [NUM_BANKS-1:0]                  bank_rvalid_i,
  input  wire logic [NUM_BANKS-1:0][BANK_DATA_W-1:0] bank_rdata_i,
  // Response channel
  output logic                                       rsp_valid_o,
  input  wire logic                                  rsp_ready_i,
  output logic      [ID_W-1:0]                       rsp_id_o,
  output logic      [DATA_W-1:0]                     rsp_data_o,
  output logic                                       busy_o
);

  // In-order queue of IDs and bank masks
  logic [ID_W-1:0]      id_q   [RSP_DEPTH];
  logic [NUM_BANKS-1:0] mask_q [RSP_DEPTH];
  logic [RSP_PTR_W-1:0] head_q;
  logic [RSP_PTR_W-1:0] tail_q;
  logic [RSP_CNT_W-1:0] count_q;
  logic [NUM_BANKS-1:0] head_mask;
  // Bank buffer holds a word for the head entry
  logic [NUM_BANKS-1:0] bank_ready;
  logic                 head_done;
  logic                 valid_q;
  logic                 pop;

  function automatic logic [RSP_PTR_W-1:0] rsp_ptr_next(logic [RSP_PTR_W-1:0] ptr);
    return (ptr == RSP_PTR_W'(RSP_DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign head_mask = mask_q[head_q];
  // Done once every masked bank has buffered its word
  assign head_done = (count_q != '0) & (&(bank_ready | ~head_mask));
  assign pop       = valid_q & rsp_ready_i;
  assign cq_full_o = count_q == RSP_CNT_W'(RSP_DEPTH);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      head_q  <= '0;
      tail_q  <= '0;
      count_q <= '0;
      valid_q <= 1'b0;
    end else begin
      if (cq_push_i) begin
        tail_q <= rsp_ptr_next(tail_q);
      end
      if (pop) begin
        head_q <= rsp_ptr_next(head_q);
      end
      count_q <= count_q + RSP_CNT_W'(cq_push_i) - RSP_CNT_W'(pop);
      // Valid follows completion by one cycle and holds until ready
      if (valid_q) begin
        valid_q <= ~rsp_ready_i;
      end else begin
        valid_q <= head_done;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (cq_push_i) begin
      id_q[tail_q]   <= cq_id_i;
      mask_q[tail_q] <= cq_mask_i;
    end
  end

  for (genvar k = 0; k < NUM_BANKS; k++) begin : g_bank
    logic [BANK_DATA_W-1:0] word_q [RSP_DEPTH];
    logic [RSP_PTR_W-1:0]   wr_ptr_q;
    logic [RSP_PTR_W-1:0]   rd_ptr_q;
    logic [RSP_CNT_W-1:0]   fill_q;
    logic                   take_word;

    // Word leaves only with a beat that used this bank
    assign take_word     = pop & head_mask[k];
    assign bank_ready[k] = fill_q != '0;
    assign rsp_data_o[k*BANK_DATA_W +: BANK_DATA_W] = head_mask[k] ? word_q[rd_ptr_q] : '0;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
        wr_ptr_q <= '0;
        rd_ptr_q <= '0;
        fill_q   <= '0;
      end else begin
        if (bank_rvalid_i[k]) begin
          wr_ptr_q <= rsp_ptr_next(wr_ptr_q);
        end
        if (take_word) begin
          rd_ptr_q <= rsp_ptr_next(rd_ptr_q);
        end
        fill_q <= fill_q + RSP_CNT_W'(bank_rvalid_i[k]) - RSP_CNT_W'(take_word);
      end
    end

    // Never stalled since the queue bounds responses in flight
    always_ff @(posedge clk_i) begin
      if (bank_rvalid_i[k]) begin
        word_q[wr_ptr_q] <= bank_rdata_i[k];
      end
    end
  end

  assign rsp_valid_o = valid_q;
  assign rsp_id_o    = id_q[head_q];
  assign busy_o      = (count_q != '0) | valid_q;

endmodule

`default_nettype wire

/* design/banked_mem_port.sv */
`default_nettype none

// Banked memory port
// Serves single-beat reads and writes from a row of 32-bit SRAM banks
// Reads may pass writes that wait on another bank

module banked_mem_port
  import axi_beat_pkg::*;
  import mem_bank_pkg::*;
(
  input  wire logic                                  clk_i,
  input  wire logic                                  arst_n_i,
  output logic                                       busy_o,
  // Write beat with address and data together
  input  wire logic                                  aw_valid_i,
  output logic                                       aw_ready_o,
  input  wire logic [ID_W-1:0]                       aw_id_i,
  input  wire logic [ADDR_W-1:0]                     aw_addr_i,
  input  wire logic [DATA_W-1:0]                     aw_wdata_i,
  input  wire logic [STRB_W-1:0]                     aw_strb_i,
  output logic                                       b_valid_o,
  input  wire logic                                  b_ready_i,
  output logic      [ID_W-1:0]                       b_id_o,
  // Read beat
  input  wire logic                                  ar_valid_i,
  output logic                                       ar_ready_o,
  input  wire logic [ID_W-1:0]                       ar_id_i,
  input  wire logic [ADDR_W-1:0]                     ar_addr_i,
  output logic                                       r_valid_o,
  input  wire logic                                  r_ready_i,
  output logic      [ID_W-1:0]                       r_id_o,
  output logic      [DATA_W-1:0]                     r_data_o,
  // SRAM banks
  output logic      [NUM_BANKS-1:0]                  mem_req_o,
  input  wire logic [NUM_BANKS-1:0]                  mem_gnt_i,
  output logic      [NUM_BANKS-1:0][ROW_W-1:0]       mem_row_o,
  output logic      [NUM_BANKS-1:0][BANK_DATA_W-1:0] mem_wdata_o,
  output logic      [NUM_BANKS-1:0][BANK_STRB_W-1:0] mem_strb_o,
  output logic      [NUM_BANKS-1:0]                  mem_we_o,
  input  wire logic [NUM_BANKS-1:0]                  mem_rvalid_i,
  input  wire logic [NUM_BANKS-1:0][BANK_DATA_W-1:0] mem_rdata_i
);

  // Write path
  logic [NUM_BANKS-1:0]                  w_req, w_gnt, w_rvalid, w_cq_mask;
  logic [ROW_W-1:0]                      w_row;
  logic [NUM_BANKS-1:0][BANK_DATA_W-1:0] w_wdata;
  logic [NUM_BANKS-1:0][BANK_STRB_W-1:0] w_strb;
  logic                                  w_cq_push, w_cq_full, w_dec_busy, w_col_busy;
  logic [ID_W-1:0]                       w_cq_id;
  // Read path
  logic [NUM_BANKS-1:0]                  r_req, r_gnt, r_rvalid, r_cq_mask;
  logic [ROW_W-1:0]                      r_row;
  logic                                  r_cq_push, r_cq_full, r_dec_busy, r_col_busy;
  logic [ID_W-1:0]                       r_cq_id;

  beat_decoder #(.WRITE_PATH(1'b1)) i_write_decoder (
    .clk_i, .arst_n_i,
    .req_valid_i (aw_valid_i), .req_ready_o (aw_ready_o), .req_id_i (aw_id_i),
    .req_addr_i  (aw_addr_i),  .req_wdata_i (aw_wdata_i), .req_strb_i (aw_strb_i),
    .path_req_o  (w_req),      .path_gnt_i  (w_gnt),      .path_row_o (w_row),
    .path_wdata_o(w_wdata),    .path_strb_o (w_strb),
    // Arbiter derives the write enable from its winner
    .path_we_o   (),
    .cq_push_o   (w_cq_push),  .cq_id_o     (w_cq_id),    .cq_mask_o  (w_cq_mask),
    .cq_full_i   (w_cq_full),  .busy_o      (w_dec_busy)
  );

  // Read path carries no write payload
  beat_decoder #(.WRITE_PATH(1'b0)) i_read_decoder (
    .clk_i, .arst_n_i,
    .req_valid_i (ar_valid_i), .req_ready_o (ar_ready_o), .req_id_i (ar_id_i),
    .req_addr_i  (ar_addr_i),  .req_wdata_i ('0),         .req_strb_i ('0),
    .path_req_o  (r_req),      .path_gnt_i  (r_gnt),      .path_row_o (r_row),
    .path_wdata_o(),           .path_strb_o (),           .path_we_o  (),
    .cq_push_o   (r_cq_push),  .cq_id_o     (r_cq_id),    .cq_mask_o  (r_cq_mask),
    .cq_full_i   (r_cq_full),  .busy_o      (r_dec_busy)
  );

  for (genvar k = 0; k < NUM_BANKS; k++) begin : g_bank
    bank_arbiter i_bank_arbiter (
      .clk_i, .arst_n_i,
      .rd_req_i    (r_req[k]),        .rd_gnt_o    (r_gnt[k]),     .rd_row_i  (r_row),
      .wr_req_i    (w_req[k]),        .wr_gnt_o    (w_gnt[k]),     .wr_row_i  (w_row),
      .wr_wdata_i  (w_wdata[k]),      .wr_strb_i   (w_strb[k]),
      .mem_req_o   (mem_req_o[k]),    .mem_gnt_i   (mem_gnt_i[k]), .mem_row_o (mem_row_o[k]),
      .mem_wdata_o (mem_wdata_o[k]),  .mem_strb_o  (mem_strb_o[k]), .mem_we_o  (mem_we_o[k]),
      .mem_rvalid_i(mem_rvalid_i[k]),
      .rd_rvalid_o (r_rvalid[k]),     .wr_rvalid_o (w_rvalid[k])
    );
  end

  // B carries no data so the joined word stays open
  beat_collector i_write_collector (
    .clk_i, .arst_n_i,
    .cq_push_i    (w_cq_push), .cq_id_i     (w_cq_id),     .cq_mask_i (w_cq_mask),
    .cq_full_o    (w_cq_full), .bank_rvalid_i(w_rvalid),   .bank_rdata_i(mem_rdata_i),
    .rsp_valid_o  (b_valid_o), .rsp_ready_i (b_ready_i),   .rsp_id_o  (b_id_o),
    .rsp_data_o   (),          .busy_o      (w_col_busy)
  );

  beat_collector i_read_collector (
    .clk_i, .arst_n_i,
    .cq_push_i    (r_cq_push), .cq_id_i     (r_cq_id),     .cq_mask_i (r_cq_mask),
    .cq_full_o    (r_cq_full), .bank_rvalid_i(r_rvalid),   .bank_rdata_i(mem_rdata_i),
    .rsp_valid_o  (r_valid_o), .rsp_ready_i (r_ready_i),   .rsp_id_o  (r_id_o),
    .rsp_data_o   (r_data_o),  .busy_o      (r_col_busy)
  );

  assign busy_o = w_dec_busy | r_dec_busy | w_col_busy | r_col_busy;

endmodule

`default_nettype wire

/* bench/sram_bank_model.sv */
`default_nettype none

// SRAM bank model for the testbench
// Grants at random and answers every granted request one cycle later

module sram_bank_model
  import axi_beat_pkg::*;
  import mem_bank_pkg::*;
#(
  // Position of this bank inside the beat
  parameter int unsigned BANK_IDX = 0
) (
  input  wire logic                   clk_i,
  input  wire logic                   arst_n_i,
  input  wire logic                   req_i,
  output logic                        gnt_o,
  input  wire logic [ROW_W-1:0]       row_i,
  input  wire logic [BANK_DATA_W-1:0] wdata_i,
  input  wire logic [BANK_STRB_W-1:0] strb_i,
  input  wire logic                   we_i,
  output logic                        rvalid_o,
  output logic      [BANK_DATA_W-1:0] rdata_o
);

  timeunit 1ns;
  timeprecision 100ps;

  localparam logic [7:0] FILL_KEY = 8'h3c;

  logic [BANK_DATA_W-1:0] mem [2**ROW_W];
  logic                   run;
  logic                   hit;
  logic [BANK_DATA_W-1:0] word;

  // Start value of a byte depends on its full byte address
  function automatic logic [7:0] fill_byte(int unsigned addr);
    return 8'(addr) ^ 8'(addr >> 8) ^ FILL_KEY;
  endfunction

  initial begin
    for (int r = 0; r < 2**ROW_W; r++) begin
      for (int b = 0; b < BANK_STRB_W; b++) begin
        mem[r][8*b +: 8] = fill_byte(r * STRB_W + BANK_IDX * BANK_STRB_W + b);
      end
    end
    gnt_o    = 1'b0;
    rvalid_o = 1'b0;
    rdata_o  = '0;
    word     = '0;
    forever begin
      // Request side is stable at the falling edge
      @(negedge clk_i);
      run = arst_n_i;
      hit = arst_n_i & req_i & gnt_o;
      if (hit) begin
        word = mem[row_i];
        if (we_i) begin
          for (int b = 0; b < BANK_STRB_W; b++) begin
            if (strb_i[b]) begin
              word[8*b +: 8] = wdata_i[8*b +: 8];
            end
          end
          mem[row_i] = word;
        end
      end
      @(posedge clk_i);
      #2;
      // Response for the grant taken at this edge
      rvalid_o = hit;
      rdata_o  = hit ? word : '0;
      // Grant roughly three cycles in four
      gnt_o    = run & ($urandom_range(3) != 0);
    end
  end

endmodule

`default_nettype wire

/* bench/banked_mem_port_tb.sv */
`default_nettype none

// Testbench for the banked memory port
// Sends single-beat writes and reads, models the SRAM banks
// and checks B and R against a byte-wide reference memory

module banked_mem_port_tb
  import axi_beat_pkg::*;
  import mem_bank_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int          CLK_PERIOD   = 40;
  localparam int          RESET_CYCLES = 16;
  localparam int          DRIVE_DELAY  = 2;
  localparam int          WAIT_LIMIT   = 400;
  localparam logic [7:0]  FILL_KEY     = 8'h3c;
  localparam logic [31:0] SEED         = 32'hc2ae;

  logic                                  clk, arst_n, busy;
  // Write beat and B
  logic                                  aw_valid, aw_ready, b_valid, b_ready;
  logic      [ID_W-1:0]                  aw_id, b_id;
  logic      [ADDR_W-1:0]                aw_addr;
  logic      [DATA_W-1:0]                aw_wdata;
  logic      [STRB_W-1:0]                aw_strb;
  // Read beat and R
  logic                                  ar_valid, ar_ready, r_valid, r_ready;
  logic      [ID_W-1:0]                  ar_id, r_id;
  logic      [ADDR_W-1:0]                ar_addr;
  logic      [DATA_W-1:0]                r_data;
  // Bank side
  logic      [NUM_BANKS-1:0]                  mem_req, mem_we;
  logic      [NUM_BANKS-1:0][ROW_W-1:0]       mem_row;
  logic      [NUM_BANKS-1:0][BANK_DATA_W-1:0] mem_wdata;
  logic      [NUM_BANKS-1:0][BANK_STRB_W-1:0] mem_strb;
  wire logic [NUM_BANKS-1:0]                  mem_gnt, mem_rvalid;
  wire logic [NUM_BANKS-1:0][BANK_DATA_W-1:0] mem_rdata;

  // Reference memory and expected responses in request order
  logic [7:0]        ref_mem [2**ADDR_W];
  logic [ID_W-1:0]   b_expect [$];
  logic [ID_W-1:0]   r_id_expect [$];
  logic [DATA_W-1:0] r_data_expect [$];
  int unsigned       req_cycles [NUM_BANKS] = '{default: 0};
  logic              stall_ready;
  int                errors = 0;
  int                checks = 0;
  int                tests_done = 0;
  int                errors_at_start = 0;

  banked_mem_port dut0 (
    .clk_i       (clk),       .arst_n_i    (arst_n),     .busy_o      (busy),
    .aw_valid_i  (aw_valid),  .aw_ready_o  (aw_ready),   .aw_id_i     (aw_id),
    .aw_addr_i   (aw_addr),   .aw_wdata_i  (aw_wdata),   .aw_strb_i   (aw_strb),
    .b_valid_o   (b_valid),   .b_ready_i   (b_ready),    .b_id_o      (b_id),
    .ar_valid_i  (ar_valid),  .ar_ready_o  (ar_ready),   .ar_id_i     (ar_id),
    .ar_addr_i   (ar_addr),   .r_valid_o   (r_valid),    .r_ready_i   (r_ready),
    .r_id_o      (r_id),      .r_data_o    (r_data),
    .mem_req_o   (mem_req),   .mem_gnt_i   (mem_gnt),    .mem_row_o   (mem_row),
    .mem_wdata_o (mem_wdata), .mem_strb_o  (mem_strb),   .mem_we_o    (mem_we),
    .mem_rvalid_i(mem_rvalid), .mem_rdata_i(mem_rdata)
  );

  for (genvar k = 0; k < NUM_BANKS; k++) begin : g_bank
    sram_bank_model #(.BANK_IDX(k)) i_bank (
      .clk_i   (clk),           .arst_n_i (arst_n),
      .req_i   (mem_req[k]),    .gnt_o    (mem_gnt[k]),
      .row_i   (mem_row[k]),    .wdata_i  (mem_wdata[k]),
      .strb_i  (mem_strb[k]),   .we_i     (mem_we[k]),
      .rvalid_o(mem_rvalid[k]), .rdata_o  (mem_rdata[k])
    );
  end

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  task automatic check_value(string name, logic [DATA_W-1:0] got, logic [DATA_W-1:0] expected);
    checks++;
    assert (got === expected) else begin
      errors++;
      $display("CHECK FAILED at time %0t: %s is %h, expected %h", $time, name, got, expected);
    end
  endtask

  task automatic report_error(string what);
    errors++;
    $display("ERROR at time %0t: %s", $time, what);
  endtask

  task automatic abort_run(string what);
    errors++;
    $display("Timed out at time %0t waiting for %s", $time, what);
    $display("TESTBENCH FAILED");
    $finish;
  endtask

  task automatic close_test(string name);
    tests_done++;
    $display("test %0d %s: %0d errors", tests_done, name, errors - errors_at_start);
    errors_at_start = errors;
  endtask

  function automatic logic [ADDR_W-1:0] row_addr(int row);
    return ADDR_W'(row * STRB_W);
  endfunction

  // Beat as the reference memory holds it with byte 0 in the low bits
  function automatic logic [DATA_W-1:0] expected_beat(int row);
    logic [DATA_W-1:0] beat;
    for (int j = 0; j < STRB_W; j++) begin
      beat[8*j +: 8] = ref_mem[row * STRB_W + j];
    end
    return beat;
  endfunction

  task automatic send_write(logic [ID_W-1:0] id, int row, logic [DATA_W-1:0] data,
                            logic [STRB_W-1:0] strb);
    int unsigned waited;
    waited = 0;
    @(posedge clk);
    #DRIVE_DELAY;
    aw_valid = 1'b1;
    aw_id    = id;
    aw_addr  = row_addr(row);
    aw_wdata = data;
    aw_strb  = strb;
    do begin
      @(negedge clk);
      waited++;
      if (waited > WAIT_LIMIT) begin
        abort_run("aw_ready_o");
      end
    end while (!aw_ready);
    // Beat is taken at the coming edge and changes only the strobed bytes
    for (int j = 0; j < STRB_W; j++) begin
      if (strb[j]) begin
        ref_mem[row * STRB_W + j] = data[8*j +: 8];
      end
    end
    b_expect.push_back(id);
    @(posedge clk);
    #DRIVE_DELAY;
    aw_valid = 1'b0;
  endtask

  task automatic send_read(logic [ID_W-1:0] id, int row);
    int unsigned waited;
    waited = 0;
    @(posedge clk);
    #DRIVE_DELAY;
    ar_valid = 1'b1;
    ar_id    = id;
    ar_addr  = row_addr(row);
    do begin
      @(negedge clk);
      waited++;
      if (waited > WAIT_LIMIT) begin
        abort_run("ar_ready_o");
      end
    end while (!ar_ready);
    r_id_expect.push_back(id);
    r_data_expect.push_back(expected_beat(row));
    @(posedge clk);
    #DRIVE_DELAY;
    ar_valid = 1'b0;
  endtask

  // Waits for every expected response and then for an idle port
  task automatic wait_idle(string what);
    int unsigned waited;
    waited = 0;
    while (b_expect.size() != 0 || r_id_expect.size() != 0) begin
      @(negedge clk);
      waited++;
      if (waited > WAIT_LIMIT) begin
        abort_run(what);
      end
    end
    @(negedge clk);
    check_value("busy_o", DATA_W'(busy), '0);
  endtask

  // Response ready is random only while stalls are on
  always @(posedge clk) begin
    #DRIVE_DELAY;
    r_ready = stall_ready ? ($urandom_range(3) != 0) : 1'b1;
    b_ready = stall_ready ? ($urandom_range(3) != 0) : 1'b1;
  end

  always @(negedge clk) begin
    if (arst_n && b_valid && b_ready) begin
      assert (b_expect.size() != 0) else report_error("B response with no write outstanding");
      if (b_expect.size() != 0) begin
        check_value("b_id_o", DATA_W'(b_id), DATA_W'(b_expect.pop_front()));
      end
    end
  end

  always @(negedge clk) begin
    if (arst_n && r_valid && r_ready) begin
      assert (r_id_expect.size() != 0) else report_error("R response with no read outstanding");
      if (r_id_expect.size() != 0) begin
        check_value("r_id_o", DATA_W'(r_id), DATA_W'(r_id_expect.pop_front()));
        check_value("r_data_o", r_data, r_data_expect.pop_front());
      end
    end
  end

  // Cycles with a bank request on each bank
  always @(negedge clk) begin
    for (int k = 0; k < NUM_BANKS; k++) begin
      if (mem_req[k]) begin
        req_cycles[k]++;
      end
    end
  end

  initial begin
    int unsigned waited;
    int unsigned seen [NUM_BANKS];
    void'($urandom(SEED));
    for (int a = 0; a < 2**ADDR_W; a++) begin
      ref_mem[a] = 8'(a) ^ 8'(a >> 8) ^ FILL_KEY;
    end
    arst_n      = 1'b0;
    aw_valid    = 1'b0;
    aw_id       = '0;
    aw_addr     = '0;
    aw_wdata    = '0;
    aw_strb     = '0;
    ar_valid    = 1'b0;
    ar_id       = '0;
    ar_addr     = '0;
    r_ready     = 1'b0;
    b_ready     = 1'b0;
    stall_ready = 1'b0;

    // Test 1 checks quiet outputs in reset and ready afterwards
    for (int c = 0; c < RESET_CYCLES; c++) begin
      @(negedge clk);
      check_value("aw_ready_o", DATA_W'(aw_ready), '0);
      check_value("ar_ready_o", DATA_W'(ar_ready), '0);
      check_value("b_valid_o", DATA_W'(b_valid), '0);
      check_value("r_valid_o", DATA_W'(r_valid), '0);
      check_value("mem_req_o", DATA_W'(mem_req), '0);
      check_value("busy_o", DATA_W'(busy), '0);
    end
    @(posedge clk);
    #DRIVE_DELAY;
    arst_n = 1'b1;
    waited = 0;
    while (!(aw_ready && ar_ready)) begin
      @(negedge clk);
      waited++;
      if (waited > WAIT_LIMIT) begin
        abort_run("ready outputs after reset");
      end
    end
    close_test("reset");

    // Test 2 writes whole beats and reads them back
    for (int i = 0; i < 8; i++) begin
      send_write(ID_W'(i), 16 + i, {$urandom, $urandom}, '1);
    end
    wait_idle("B of full writes");
    for (int i = 0; i < 8; i++) begin
      send_read(ID_W'(8 + i), 16 + i);
    end
    wait_idle("R of full writes");
    close_test("full writes");

    // Test 3 uses strobes that leave one bank or some bytes alone
    seen = req_cycles;
    send_write(4'd3, 32, {$urandom, $urandom}, 8'h0f);
    wait_idle("B of bank 0 write");
    check_value("mem_req_o[1] cycles", DATA_W'(req_cycles[1] - seen[1]), '0);
    seen = req_cycles;
    send_write(4'd4, 33, {$urandom, $urandom}, 8'hf0);
    wait_idle("B of bank 1 write");
    check_value("mem_req_o[0] cycles", DATA_W'(req_cycles[0] - seen[0]), '0);
    send_write(4'd5, 34, {$urandom, $urandom}, 8'h5a);
    wait_idle("B of byte write");
    for (int i = 0; i < 3; i++) begin
      send_read(ID_W'(6 + i), 32 + i);
    end
    wait_idle("R of partial writes");
    close_test("partial strobes");

    // Test 4 sends a write with no strobes at all
    seen = req_cycles;
    send_write(4'd9, 40, {$urandom, $urandom}, '0);
    wait_idle("B of empty write");
    check_value("mem_req_o[0] cycles", DATA_W'(req_cycles[0] - seen[0]), '0);
    check_value("mem_req_o[1] cycles", DATA_W'(req_cycles[1] - seen[1]), '0);
    send_read(4'd10, 40);
    wait_idle("R after empty write");
    close_test("empty strobes");

    // Test 5 mixes both paths on separate rows under back-pressure
    stall_ready = 1'b1;
    fork
      for (int i = 0; i < 12; i++) begin
        send_write(ID_W'(i), 64 + i, {$urandom, $urandom}, STRB_W'($urandom));
        repeat ($urandom_range(2)) @(posedge clk);
      end
      for (int i = 0; i < 12; i++) begin
        send_read(ID_W'(i + 4), 16 + i);
        repeat ($urandom_range(2)) @(posedge clk);
      end
    join
    wait_idle("responses under back-pressure");
    stall_ready = 1'b0;
    // Every row written under back-pressure is read back
    for (int i = 0; i < 12; i++) begin
      send_read(ID_W'(i), 64 + i);
    end
    wait_idle("R of mixed writes");
    close_test("interleaved traffic");

    $display("%0d tests run, %0d checks, %0d errors", tests_done, checks, errors);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* sim.f */
design/axi_beat_pkg.sv
design/mem_bank_pkg.sv
design/beat_decoder.sv
design/bank_arbiter.sv
design/beat_collector.sv
design/banked_mem_port.sv
bench/sram_bank_model.sv
bench/banked_mem_port_tb.sv

/* Makefile */
# Verilator build and run of the banked memory port testbench
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps -Wno-fatal
TOP       := banked_mem_port_tb
FILELIST  := sim.f
BUILD_DIR := obj_dir
LOG       := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
